// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(BUILD_DIR)

// ==== project.f ====
+incdir+tb
src/cpu_pkg.sv
src/control.sv
src/register_file.sv
src/alu.sv
src/pc_control.sv
src/memory.sv
src/cpu_core.sv
src/apb_debug_port.sv
src/cpu_top.sv
tb/cpu_tb.sv

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            step,
    input  logic            clear,
    input  cpu_pkg::alu_op_e op,
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    output cpu_pkg::word_t   result,
    output cpu_pkg::flags_t  flags
);
    import cpu_pkg::*;

    word_t       sum;
    word_t       diff;
    logic        v_add;
    logic        v_sub;
    logic [3:0]  shamt;
    logic [31:0] rot;
    flags_t      next_flags;

    assign sum   = a + b;
    assign diff  = a - b;
    // Signed overflow, wrapped result
    assign v_add = (a[15] == b[15]) && (sum[15] != a[15]);
    assign v_sub = (a[15] != b[15]) && (diff[15] != a[15]);
    assign shamt = b[3:0];
    assign rot   = {a, a} >> shamt;

    always_comb begin
        case (op)
            ALU_ADD: result = sum;
            ALU_SUB: result = diff;
            ALU_XOR: result = a ^ b;
            ALU_SLL: result = a << shamt;
            ALU_SRA: result = $signed(a) >>> shamt;
            ALU_ROR: result = rot[15:0];
            ALU_LLB: result = {a[15:8], b[7:0]};
            ALU_LHB: result = {b[7:0], a[7:0]};
            default: result = b;
        endcase
    end

    always_comb begin
        next_flags = flags;
        case (op)
            ALU_ADD: next_flags = {sum[15], v_add, sum == '0};
            ALU_SUB: next_flags = {diff[15], v_sub, diff == '0};
            // Logic and shifts touch Z only
            ALU_XOR, ALU_SLL, ALU_SRA, ALU_ROR: next_flags[0] = (result == '0);
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flags <= '0;
        end else if (clear) begin
            flags <= '0;
        end else if (step) begin
            flags <= next_flags;
        end
    end

endmodule

// ==== src/apb_debug_port.sv ====
`timescale 1ns/1ps

module apb_debug_port (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           psel,
    input  logic           penable,
    input  logic           pwrite,
    input  cpu_pkg::word_t paddr,
    input  cpu_pkg::word_t pwdata,
    output cpu_pkg::word_t prdata,
    output logic           pready,
    output logic           pslverr,
    output logic           run,
    output logic           start,
    input  logic           hlt,
    input  cpu_pkg::word_t core_pc,
    input  cpu_pkg::word_t core_daddr,
    input  cpu_pkg::word_t core_dwdata,
    input  logic           core_dwrite,
    output cpu_pkg::word_t imem_addr,
    output cpu_pkg::word_t imem_wdata,
    output logic           imem_write,
    input  cpu_pkg::word_t imem_rdata,
    output cpu_pkg::word_t dmem_addr,
    output cpu_pkg::word_t dmem_wdata,
    output logic           dmem_write,
    input  cpu_pkg::word_t dmem_rdata
);
    import cpu_pkg::*;

    dbg_region_e region;
    logic        access;
    logic        err;
    logic        wr_ok;
    logic        apb_imem;
    logic        apb_dmem;
    word_t       apb_index;

    assign region    = dbg_region_e'(paddr[13:12]);
    assign access    = psel & penable;
    assign apb_index = {5'b0, paddr[11:1]};

    // Illegal region, memory while running, or reserved CTRL bit
    assign err = (region == RGN_NONE) ||
                 (run && (region == RGN_IMEM || region == RGN_DMEM)) ||
                 (region == RGN_CTRL && pwrite && pwdata[1]);

    assign pready  = 1'b1;
    assign pslverr = access & err;
    assign wr_ok   = access & pwrite & ~err;

    // Pulse on the 0 to 1 write, pc and flags clear at that edge
    assign start = wr_ok & (region == RGN_CTRL) & pwdata[0] & ~run;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run <= 1'b0;
        end else if (wr_ok && region == RGN_CTRL) begin
            run <= pwdata[0];
        end
    end

    // Stopped core keeps fetching at pc unless APB addresses the memory,
    // so hlt stays readable over CTRL
    assign apb_imem = ~run & psel & (region == RGN_IMEM);
    assign apb_dmem = ~run & psel & (region == RGN_DMEM);

    assign imem_addr  = apb_imem ? apb_index : {1'b0, core_pc[15:1]};
    assign imem_wdata = pwdata;
    assign imem_write = wr_ok & (region == RGN_IMEM);

    assign dmem_addr  = apb_dmem ? apb_index : {1'b0, core_daddr[15:1]};
    assign dmem_wdata = run ? core_dwdata : pwdata;
    assign dmem_write = run ? core_dwrite : (wr_ok & (region == RGN_DMEM));

    always_comb begin
        case (region)
            RGN_CTRL: prdata = {14'b0, hlt, run};
            RGN_IMEM: prdata = imem_rdata;
            RGN_DMEM: prdata = dmem_rdata;
            default:  prdata = '0;
        endcase
    end

endmodule

// ==== src/control.sv ====
`timescale 1ns/1ps

module control (
    input  cpu_pkg::opcode_e opcode,
    output cpu_pkg::ctrl_t   ctrl
);
    import cpu_pkg::*;

    always_comb begin
        // Inactive defaults, ALU passes b so flags hold
        ctrl        = '0;
        ctrl.alu_op = ALU_PASS_B;

        case (opcode)
            OP_ADD: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = ALU_ADD;
            end
            OP_SUB: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = ALU_SUB;
            end
            OP_XOR: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = ALU_XOR;
            end
            OP_SLL, OP_SRA, OP_ROR: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = (opcode == OP_SLL) ? ALU_SLL :
                                   (opcode == OP_SRA) ? ALU_SRA : ALU_ROR;
            end
            OP_LW: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_enable = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            OP_SW: begin
                ctrl.mem_enable = 1'b1;
                ctrl.mem_write  = 1'b1;
            end
            OP_LLB, OP_LHB: begin
                ctrl.reg_write    = 1'b1;
                ctrl.alu_src_imm  = 1'b1;
                ctrl.imm8_select  = 1'b1;
                ctrl.rd_as_source = 1'b1;
                ctrl.alu_op       = (opcode == OP_LLB) ? ALU_LLB : ALU_LHB;
            end
            OP_B:   ctrl.branch_kind = BR_COND;
            OP_BR:  ctrl.branch_kind = BR_REG;
            OP_PCS: begin
                ctrl.reg_write = 1'b1;
                ctrl.pc_to_reg = 1'b1;
            end
            OP_HLT: ctrl.branch_kind = BR_HALT;
            // Opcodes 3 and 7 keep the defaults
            default: ;
        endcase
    end

endmodule

// ==== src/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           step,
    input  logic           start,
    input  cpu_pkg::word_t instr,
    output cpu_pkg::word_t pc,
    output logic           hlt,
    output cpu_pkg::word_t dmem_addr,
    output cpu_pkg::word_t dmem_wdata,
    output logic           dmem_write,
    input  cpu_pkg::word_t dmem_rdata
);
    import cpu_pkg::*;

    opcode_e  opcode;
    ctrl_t    ctrl;
    reg_idx_t rd;
    reg_idx_t src1;
    reg_idx_t src2;
    word_t    read1;
    word_t    read2;
    word_t    imm4;
    word_t    imm8;
    word_t    alu_b;
    word_t    alu_result;
    word_t    wb_data;
    word_t    next_pc;
    word_t    pc_plus2;
    flags_t   flags;
    logic     exec_en;

    assign opcode = opcode_e'(instr[15:12]);

    control control_i (
        .opcode (opcode),
        .ctrl   (ctrl)
    );

    assign hlt = (ctrl.branch_kind == BR_HALT);
    // One instruction per cycle while running and not halted
    assign exec_en = step & ~hlt;

    // Field decode
    assign rd   = instr[11:8];
    assign src1 = ctrl.rd_as_source ? rd : instr[7:4];
    assign src2 = ctrl.mem_write ? rd : instr[3:0];

    assign imm4  = {{12{instr[3]}}, instr[3:0]};
    assign imm8  = {8'h00, instr[7:0]};
    assign alu_b = ctrl.alu_src_imm ? (ctrl.imm8_select ? imm8 : imm4) : read2;

    register_file register_file_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .src1       (src1),
        .src2       (src2),
        .dst        (rd),
        .write_en   (ctrl.reg_write & exec_en),
        .write_data (wb_data),
        .read1      (read1),
        .read2      (read2)
    );

    alu alu_i (
        .clk    (clk),
        .arst_n (arst_n),
        .step   (exec_en),
        .clear  (start),
        .op     (ctrl.alu_op),
        .a      (read1),
        .b      (alu_b),
        .result (alu_result),
        .flags  (flags)
    );

    // Word aligned base plus doubled offset
    assign dmem_addr  = (read1 & 16'hFFFE) + {imm4[14:0], 1'b0};
    assign dmem_wdata = read2;
    assign dmem_write = ctrl.mem_enable & ctrl.mem_write & exec_en;

    assign wb_data = ctrl.pc_to_reg  ? pc_plus2 :
                     ctrl.mem_to_reg ? dmem_rdata : alu_result;

    pc_control pc_control_i (
        .branch_kind (ctrl.branch_kind),
        .cond        (instr[11:9]),
        .offset      (instr[8:0]),
        .flags       (flags),
        .rs_value    (read1),
        .pc          (pc),
        .next_pc     (next_pc),
        .pc_plus2    (pc_plus2)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (start) begin
            pc <= '0;
        end else if (exec_en) begin
            pc <= next_pc;
        end
    end

endmodule

// ==== src/cpu_pkg.sv ====
package cpu_pkg;

    typedef logic [15:0] word_t;
    typedef logic [3:0]  reg_idx_t;

    // N is bit 2, V bit 1, Z bit 0
    typedef logic [2:0]  flags_t;

    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_XOR  = 4'd2,
        OP_RSV3 = 4'd3,
        OP_SLL  = 4'd4,
        OP_SRA  = 4'd5,
        OP_ROR  = 4'd6,
        OP_RSV7 = 4'd7,
        OP_LW   = 4'd8,
        OP_SW   = 4'd9,
        OP_LLB  = 4'd10,
        OP_LHB  = 4'd11,
        OP_B    = 4'd12,
        OP_BR   = 4'd13,
        OP_PCS  = 4'd14,
        OP_HLT  = 4'd15
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_SLL,
        ALU_SRA,
        ALU_ROR,
        ALU_LLB,
        ALU_LHB,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE = 2'd0,
        BR_COND = 2'd1,
        BR_REG  = 2'd2,
        BR_HALT = 2'd3
    } branch_e;

    typedef struct packed {
        logic    reg_write;
        logic    alu_src_imm;
        logic    mem_enable;
        logic    mem_write;
        logic    mem_to_reg;
        logic    pc_to_reg;
        logic    imm8_select;
        logic    rd_as_source;
        branch_e branch_kind;
        alu_op_e alu_op;
    } ctrl_t;

    // Debug port region, paddr[13:12]
    typedef enum logic [1:0] {
        RGN_CTRL = 2'b00,
        RGN_IMEM = 2'b01,
        RGN_DMEM = 2'b10,
        RGN_NONE = 2'b11
    } dbg_region_e;

endpackage

// ==== src/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top #(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 256
) (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           psel,
    input  logic           penable,
    input  logic           pwrite,
    input  cpu_pkg::word_t paddr,
    input  cpu_pkg::word_t pwdata,
    output cpu_pkg::word_t prdata,
    output logic           pready,
    output logic           pslverr,
    output logic           hlt,
    output cpu_pkg::word_t pc
);
    import cpu_pkg::*;

    logic  run;
    logic  start;
    word_t core_daddr;
    word_t core_dwdata;
    logic  core_dwrite;
    word_t imem_addr;
    word_t imem_wdata;
    logic  imem_write;
    word_t imem_rdata;
    word_t dmem_addr;
    word_t dmem_wdata;
    logic  dmem_write;
    word_t dmem_rdata;

    // Core gates its own step with hlt
    cpu_core core_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .step       (run),
        .start      (start),
        .instr      (imem_rdata),
        .pc         (pc),
        .hlt        (hlt),
        .dmem_addr  (core_daddr),
        .dmem_wdata (core_dwdata),
        .dmem_write (core_dwrite),
        .dmem_rdata (dmem_rdata)
    );

    apb_debug_port dbg_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .run         (run),
        .start       (start),
        .hlt         (hlt),
        .core_pc     (pc),
        .core_daddr  (core_daddr),
        .core_dwdata (core_dwdata),
        .core_dwrite (core_dwrite),
        .imem_addr   (imem_addr),
        .imem_wdata  (imem_wdata),
        .imem_write  (imem_write),
        .imem_rdata  (imem_rdata),
        .dmem_addr   (dmem_addr),
        .dmem_wdata  (dmem_wdata),
        .dmem_write  (dmem_write),
        .dmem_rdata  (dmem_rdata)
    );

    memory #(.WORDS(IMEM_WORDS)) imem_i (
        .clk   (clk),
        .addr  (imem_addr),
        .wdata (imem_wdata),
        .write (imem_write),
        .rdata (imem_rdata)
    );

    memory #(.WORDS(DMEM_WORDS)) dmem_i (
        .clk   (clk),
        .addr  (dmem_addr),
        .wdata (dmem_wdata),
        .write (dmem_write),
        .rdata (dmem_rdata)
    );

endmodule

// ==== src/memory.sv ====
`timescale 1ns/1ps

module memory #(
    parameter int WORDS = 256
) (
    input  logic           clk,
    input  cpu_pkg::word_t addr,
    input  cpu_pkg::word_t wdata,
    input  logic           write,
    output cpu_pkg::word_t rdata
);
    import cpu_pkg::*;

    localparam int AW = (WORDS > 1) ? $clog2(WORDS) : 1;

    word_t      mem [WORDS];
    logic [AW-1:0] index;

    // Word index, upper bits wrap
    assign index = addr[AW-1:0];

    // Asynchronous read
    assign rdata = mem[index];

    always_ff @(posedge clk) begin
        if (write) begin
            mem[index] <= wdata;
        end
    end

endmodule

// ==== src/pc_control.sv ====
`timescale 1ns/1ps

module pc_control (
    input  cpu_pkg::branch_e branch_kind,
    input  logic [2:0]       cond,
    input  logic [8:0]       offset,
    input  cpu_pkg::flags_t  flags,
    input  cpu_pkg::word_t   rs_value,
    input  cpu_pkg::word_t   pc,
    output cpu_pkg::word_t   next_pc,
    output cpu_pkg::word_t   pc_plus2
);
    import cpu_pkg::*;

    logic  n;
    logic  v;
    logic  z;
    logic  taken;
    word_t b_offset;

    assign n = flags[2];
    assign v = flags[1];
    assign z = flags[0];

    assign pc_plus2 = pc + 16'd2;
    // Word offset, sign extended and doubled
    assign b_offset = {{6{offset[8]}}, offset, 1'b0};

    always_comb begin
        case (cond)
            3'b000:  taken = ~z;
            3'b001:  taken = z;
            3'b010:  taken = ~z & ~n;
            3'b011:  taken = n;
            3'b100:  taken = z | ~n;
            3'b101:  taken = n | z;
            3'b110:  taken = v;
            default: taken = 1'b1;
        endcase
    end

    always_comb begin
        case (branch_kind)
            BR_COND: next_pc = taken ? pc_plus2 + b_offset : pc_plus2;
            BR_REG:  next_pc = rs_value;
            BR_HALT: next_pc = pc;
            default: next_pc = pc_plus2;
        endcase
    end

endmodule

// ==== src/register_file.sv ====
`timescale 1ns/1ps

module register_file (
    input  logic             clk,
    input  logic             arst_n,
    input  cpu_pkg::reg_idx_t src1,
    input  cpu_pkg::reg_idx_t src2,
    input  cpu_pkg::reg_idx_t dst,
    input  logic             write_en,
    input  cpu_pkg::word_t    write_data,
    output cpu_pkg::word_t    read1,
    output cpu_pkg::word_t    read2
);
    import cpu_pkg::*;

    word_t regs [16];

    // No bypass, a same-cycle read sees the old value
    assign read1 = regs[src1];
    assign read2 = regs[src2];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[dst] <= write_data;
        end
    end

endmodule

// ==== tb/cpu_tb_programs.svh ====
// Test table, one program and one set of expected values per entry
localparam int NUM_TESTS = 6;

// Program words in fetch order, unused slots hold HLT
localparam word_t PROGRAMS [NUM_TESTS][16] = '{
    // r1=7ff0 r2=0025, add r3, sub r4=r2-r3, add r5=r4+r4, sw r5 to 0x04
    '{16'hA1F0, 16'hB17F, 16'hA225, 16'hB200,
      16'h0312, 16'h1423, 16'h0544, 16'h9502,
      16'hF000, 16'hF000, 16'hF000, 16'hF000,
      16'hF000, 16'hF000, 16'hF000, 16'hF000},
    // r1=8c31 r2=00ff, xor, sll 4, sra 3, ror 5, sw r6 to 0x06
    '{16'hA131, 16'hB18C, 16'hA2FF, 16'hB200,
      16'h2312, 16'h4434, 16'h5543, 16'h6655,
      16'h9603, 16'hF000, 16'hF000, 16'hF000,
      16'hF000, 16'hF000, 16'hF000, 16'hF000},
    // r1=0023, lw r2 from r1-2 (masked base), sw r2 to 0x08
    '{16'hA123, 16'hB100, 16'h821F, 16'h9204,
      16'hF000, 16'hF000, 16'hF000, 16'hF000,
      16'hF000, 16'hF000, 16'hF000, 16'hF000,
      16'hF000, 16'hF000, 16'hF000, 16'hF000},
    // Count r1 from 5 down, r3 counts up, b neq loop, b ovfl not taken
    '{16'hA105, 16'hB100, 16'hA201, 16'hB200,
      16'hA300, 16'hB300, 16'h0332, 16'h1112,
      16'hC1FD, 16'hCC01, 16'h9305, 16'hF000,
      16'hF000, 16'hF000, 16'hF000, 16'hF000},
    // r1=000a, pcs r2 at 0x04, br r1 over a hlt, sw r2 to 0x0c
    '{16'hA10A, 16'hB100, 16'hE200, 16'hD010,
      16'hF000, 16'h9206, 16'hF000, 16'hF000,
      16'hF000, 16'hF000, 16'hF000, 16'hF000,
      16'hF000, 16'hF000, 16'hF000, 16'hF000},
    // r1=6677, sw r1 to 0x0e, then illegal APB accesses
    '{16'hA177, 16'hB166, 16'h9107, 16'hF000,
      16'hF000, 16'hF000, 16'hF000, 16'hF000,
      16'hF000, 16'hF000, 16'hF000, 16'hF000,
      16'hF000, 16'hF000, 16'hF000, 16'hF000}
};

// preload, check_addr, exp_data, exp_pc, exp_apb_err
localparam check_t CHECKS [NUM_TESTS] = '{
    '{16'h1111, 16'h0004, 16'h0020, 16'h0010, 1'b0},
    '{16'h2222, 16'h0006, 16'hE7CC, 16'h0012, 1'b0},
    '{16'h5A3C, 16'h0008, 16'h5A3C, 16'h0008, 1'b0},
    '{16'h4444, 16'h000A, 16'h0005, 16'h0016, 1'b0},
    '{16'h5555, 16'h000C, 16'h0006, 16'h000C, 1'b0},
    '{16'h6666, 16'h000E, 16'h6677, 16'h0006, 1'b1}
};

// ==== tb/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;
    import cpu_pkg::*;

    typedef struct packed {
        word_t preload;
        word_t check_addr;
        word_t exp_data;
        word_t exp_pc;
        logic  exp_apb_err;
    } check_t;

`include "cpu_tb_programs.svh"

    localparam word_t CTRL_BASE    = 16'h0000;
    localparam word_t IMEM_BASE    = 16'h1000;
    localparam word_t DMEM_BASE    = 16'h2000;
    localparam word_t NONE_BASE    = 16'h3000;
    localparam word_t PRELOAD_ADDR = 16'h0020;

    localparam int RESET_CYCLES = 10;
    // Two cycles per APB transfer of a program word
    localparam int LOAD_CYCLES  = 2 * 16;
    localparam int RUN_CYCLES   = 64;
    localparam int CYCLE_LIMIT  = NUM_TESTS * (LOAD_CYCLES + RUN_CYCLES) + RESET_CYCLES;

    logic  clk;
    logic  arst_n;
    logic  psel;
    logic  penable;
    logic  pwrite;
    word_t paddr;
    word_t pwdata;
    word_t prdata;
    logic  pready;
    logic  pslverr;
    logic  hlt;
    word_t pc;

    int test_errors;
    int pass_count;
    int fail_count;
    int cycle_count;

    cpu_top #(
        .IMEM_WORDS (256),
        .DMEM_WORDS (256)
    ) dut_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .hlt     (hlt),
        .pc      (pc)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Starts and ends 2 ns after a rising edge
    task automatic apb_transfer(input logic write, input word_t addr, input word_t wdata,
                                output word_t rdata, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #2;
        penable = 1'b1;
        // Response is settled by the falling edge
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        check_true(pready, "pready was low in the access phase");
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic wait_for_halt(output logic halted);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!hlt && waited < RUN_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        halted = hlt;
        @(posedge clk);
        #2;
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t got);
        assert (got === exp) else begin
            $display("error %s exp 0x%h got 0x%h", name, exp, got);
            test_errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("%s", what);
            test_errors++;
        end
    endtask

    task automatic run_test(input int t);
        word_t rdata;
        logic  err;
        logic  halted;
        test_errors = 0;
        for (int j = 0; j < 16; j++) begin
            apb_transfer(1'b1, IMEM_BASE + 16'(2 * j), PROGRAMS[t][j], rdata, err);
            check_true(!err, "unexpected pslverr while loading the program");
        end
        apb_transfer(1'b1, DMEM_BASE + PRELOAD_ADDR, CHECKS[t].preload, rdata, err);
        check_true(!err, "unexpected pslverr on the data preload");

        apb_transfer(1'b1, CTRL_BASE, 16'h0001, rdata, err);
        wait_for_halt(halted);
        check_true(halted, $sformatf("timeout, no halt within %0d cycles", RUN_CYCLES));
        check_word("pc", CHECKS[t].exp_pc, pc);

        if (CHECKS[t].exp_apb_err) begin
            // Memory is locked while run is set
            apb_transfer(1'b1, IMEM_BASE, 16'h0000, rdata, err);
            check_true(err, "IMEM write while running did not raise pslverr");
            apb_transfer(1'b0, NONE_BASE, 16'h0000, rdata, err);
            check_true(err, "access to the unmapped region did not raise pslverr");
        end

        apb_transfer(1'b1, CTRL_BASE, 16'h0000, rdata, err);
        apb_transfer(1'b0, CTRL_BASE, 16'h0000, rdata, err);
        // Expect hlt set and run clear
        check_word("ctrl", 16'h0002, rdata);

        apb_transfer(1'b0, DMEM_BASE + CHECKS[t].check_addr, 16'h0000, rdata, err);
        check_true(!err, "unexpected pslverr on the result read");
        check_word("dmem_rdata", CHECKS[t].exp_data, rdata);

        if (test_errors == 0) begin
            $display("test %0d passed", t);
            pass_count++;
        end else begin
            $display("test %0d failed with %0d errors", t, test_errors);
            fail_count++;
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        arst_n      = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        test_errors = 0;
        pass_count  = 0;
        fail_count  = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        arst_n = 1'b1;

        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end

        $display("summary %0d passed %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
